// File: logic/lc3b_types.sv
package lc3b_types;

    typedef logic [15:0] lc3b_word;
    typedef logic [2:0]  lc3b_reg;
    typedef logic [2:0]  lc3b_nzp;
    // Bit 1 is the high byte
    typedef logic [1:0]  lc3b_mem_wmask;

    typedef enum logic [3:0] {
        op_br  = 4'b0000,
        op_add = 4'b0001,
        op_ldb = 4'b0010,
        op_stb = 4'b0011,
        op_jsr = 4'b0100,
        op_and = 4'b0101,
        op_ldr = 4'b0110,
        op_str = 4'b0111,
        op_not = 4'b1001,
        op_jmp = 4'b1100,
        op_shf = 4'b1101,
        op_lea = 4'b1110
    } lc3b_opcode;

    typedef enum logic [2:0] {
        alu_add,
        alu_and,
        alu_not,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_pass
    } lc3b_aluop;

    // Second ALU operand
    localparam logic [1:0] alumux_reg  = 2'd0;
    localparam logic [1:0] alumux_imm4 = 2'd1;
    localparam logic [1:0] alumux_imm5 = 2'd2;
    localparam logic [1:0] alumux_off6 = 2'd3;

    // Register file write data
    localparam logic [1:0] regfilemux_alu   = 2'd0;
    localparam logic [1:0] regfilemux_mem   = 2'd1;
    localparam logic [1:0] regfilemux_pcoff = 2'd2;
    localparam logic [1:0] regfilemux_link  = 2'd3;

    typedef struct packed {
        lc3b_aluop  aluop;
        logic [1:0] alumux_sel;
        logic       offset6_lsse;
    } lc3b_control_word_ex;

    typedef struct packed {
        logic d_mem_read;
        logic d_mem_write;
    } lc3b_control_word_mem;

    typedef struct packed {
        lc3b_opcode opcode;
        logic       load_regfile;
        logic       load_cc;
        logic [1:0] regfilemux_sel;
        logic       destmux_sel;
    } lc3b_control_word_wb;

    typedef struct packed {
        lc3b_control_word_ex  ex;
        lc3b_control_word_mem mem;
        lc3b_control_word_wb  wb;
        logic                 src2mux_sel;
    } lc3b_control_word;

endpackage : lc3b_types

// File: logic/cpu_control.sv
`timescale 1ns/1ps

module cpu_control (
    input  lc3b_types::lc3b_opcode       opcode,
    input  logic                         ir_4,
    input  logic                         ir_5,
    input  logic                         ir_11,
    output lc3b_types::lc3b_control_word cw
);
    import lc3b_types::*;

    always_comb begin
        cw = '0;
        cw.ex.aluop = alu_pass;
        cw.ex.alumux_sel = alumux_reg;
        cw.wb.opcode = opcode;
        cw.wb.regfilemux_sel = regfilemux_alu;

        case (opcode)
            op_add, op_and: begin
                cw.ex.aluop = (opcode == op_add) ? alu_add : alu_and;
                cw.ex.alumux_sel = ir_5 ? alumux_imm5 : alumux_reg;
                cw.wb.load_regfile = 1'b1;
                cw.wb.load_cc = 1'b1;
            end
            op_not: begin
                cw.ex.aluop = alu_not;
                cw.wb.load_regfile = 1'b1;
                cw.wb.load_cc = 1'b1;
            end
            op_shf: begin
                if (!ir_4) begin
                    cw.ex.aluop = alu_sll;
                end else if (ir_5) begin
                    cw.ex.aluop = alu_sra;
                end else begin
                    cw.ex.aluop = alu_srl;
                end
                cw.ex.alumux_sel = alumux_imm4;
                cw.wb.load_regfile = 1'b1;
                cw.wb.load_cc = 1'b1;
            end
            op_lea: begin
                cw.wb.load_regfile = 1'b1;
                cw.wb.regfilemux_sel = regfilemux_pcoff;
            end
            op_ldr, op_ldb: begin
                cw.ex.aluop = alu_add;
                cw.ex.alumux_sel = alumux_off6;
                cw.ex.offset6_lsse = (opcode == op_ldr);
                cw.mem.d_mem_read = 1'b1;
                cw.wb.load_regfile = 1'b1;
                cw.wb.load_cc = 1'b1;
                cw.wb.regfilemux_sel = regfilemux_mem;
            end
            op_str, op_stb: begin
                cw.ex.aluop = alu_add;
                cw.ex.alumux_sel = alumux_off6;
                cw.ex.offset6_lsse = (opcode == op_str);
                cw.mem.d_mem_write = 1'b1;
                // Source register sits in the DR field
                cw.src2mux_sel = 1'b1;
            end
            op_jmp: begin
                // Bits 3:0 are zero here, so the ALU hands the base through
                cw.ex.aluop = alu_add;
                cw.ex.alumux_sel = alumux_imm4;
            end
            op_jsr: begin
                if (!ir_11) begin
                    cw.ex.aluop = alu_add;
                    cw.ex.alumux_sel = alumux_imm4;
                end
                cw.wb.load_regfile = 1'b1;
                cw.wb.regfilemux_sel = regfilemux_link;
                cw.wb.destmux_sel = 1'b1;
            end
            default: ;
        endcase
    end

endmodule : cpu_control

// File: logic/cpu_regfile.sv
`timescale 1ns/1ps

module cpu_regfile (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  load,
    input  lc3b_types::lc3b_word  in,
    input  lc3b_types::lc3b_reg   src_a,
    input  lc3b_types::lc3b_reg   src_b,
    input  lc3b_types::lc3b_reg   dest,
    output lc3b_types::lc3b_word  reg_a,
    output lc3b_types::lc3b_word  reg_b
);
    import lc3b_types::*;

    lc3b_word data [8];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 8; i++) begin
                data[i] <= '0;
            end
        end else if (load) begin
            data[dest] <= in;
        end
    end

    // Write-through so a reader in ID sees the WB value
    always_comb begin
        reg_a = (load && dest == src_a) ? in : data[src_a];
        reg_b = (load && dest == src_b) ? in : data[src_b];
    end

endmodule : cpu_regfile

// File: logic/cpu_alu.sv
`timescale 1ns/1ps

module cpu_alu (
    input  lc3b_types::lc3b_aluop aluop,
    input  lc3b_types::lc3b_word  a,
    input  lc3b_types::lc3b_word  b,
    output lc3b_types::lc3b_word  f
);
    import lc3b_types::*;

    logic [3:0] shamt;

    assign shamt = b[3:0];

    always_comb begin
        case (aluop)
            alu_add: begin
                f = a + b;
            end
            alu_and: begin
                f = a & b;
            end
            alu_not: begin
                f = ~a;
            end
            alu_sll: begin
                f = a << shamt;
            end
            alu_srl: begin
                f = a >> shamt;
            end
            alu_sra: begin
                f = lc3b_word'($signed(a) >>> shamt);
            end
            default: begin
                f = b;
            end
        endcase
    end

endmodule : cpu_alu

// File: logic/cpu_datapath.sv
`timescale 1ns/1ps

module cpu_datapath #(
    parameter lc3b_types::lc3b_word start_pc = '0
) (
    input  logic                          clk,
    input  logic                          rst,

    // Control interface
    input  lc3b_types::lc3b_control_word  cw,
    output lc3b_types::lc3b_opcode        opcode,
    output logic                          ir_4,
    output logic                          ir_5,
    output logic                          ir_11,

    // Instruction memory
    output lc3b_types::lc3b_word          i_mem_address,
    input  lc3b_types::lc3b_word          i_mem_rdata,

    // Data memory
    output lc3b_types::lc3b_word          d_mem_address,
    input  lc3b_types::lc3b_word          d_mem_rdata,
    output lc3b_types::lc3b_word          d_mem_wdata,
    output logic                          d_mem_read,
    output logic                          d_mem_write,
    output lc3b_types::lc3b_mem_wmask     d_mem_byte_enable
);
    import lc3b_types::*;

    typedef struct packed {
        logic     valid;
        lc3b_word pc;
        lc3b_word ir;
    } if_id_t;

    typedef struct packed {
        logic                 valid;
        lc3b_control_word_ex  ex;
        lc3b_control_word_mem mem;
        lc3b_control_word_wb  wb;
        lc3b_word             pc;
        lc3b_word             ir;
        lc3b_word             src_a_data;
        lc3b_word             src_b_data;
    } id_ex_t;

    typedef struct packed {
        logic                 valid;
        lc3b_control_word_mem mem;
        lc3b_control_word_wb  wb;
        lc3b_word             pc;
        lc3b_word             ir;
        lc3b_word             alu;
        lc3b_word             wdata;
        lc3b_mem_wmask        wmask;
    } ex_mem_t;

    typedef struct packed {
        logic                valid;
        lc3b_control_word_wb wb;
        lc3b_word            pc;
        lc3b_word            ir;
        lc3b_word            alu;
        lc3b_word            rdata;
    } mem_wb_t;

    if_id_t  if_id;
    id_ex_t  id_ex;
    ex_mem_t ex_mem;
    mem_wb_t mem_wb;

    lc3b_word      pc;
    lc3b_word      pc_plus2;
    lc3b_word      pc_next;
    lc3b_reg       src_b;
    lc3b_reg       dest;
    lc3b_word      reg_a;
    lc3b_word      reg_b;
    lc3b_word      imm4;
    lc3b_word      imm5;
    lc3b_word      off6;
    lc3b_word      alumux_out;
    lc3b_word      alu_out;
    lc3b_word      store_data;
    lc3b_mem_wmask store_mask;
    lc3b_word      adj9;
    lc3b_word      adj11;
    lc3b_word      pc_plus_off;
    lc3b_word      load_data;
    lc3b_word      regfile_in;
    lc3b_nzp       gencc;
    lc3b_nzp       cc;
    logic          br_enable;
    logic          wb_load_regfile;

    // Fetch
    assign pc_plus2 = pc + 16'd2;
    assign i_mem_address = pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= start_pc;
        end else begin
            pc <= pc_next;
        end
    end

    always_ff @(posedge clk) begin
        if_id.pc <= pc_plus2;
        if_id.ir <= i_mem_rdata;
        if (rst) begin
            if_id.valid <= 1'b0;
        end else begin
            if_id.valid <= 1'b1;
        end
    end

    // Decode
    assign opcode = lc3b_opcode'(if_id.ir[15:12]);
    assign ir_4 = if_id.ir[4];
    assign ir_5 = if_id.ir[5];
    assign ir_11 = if_id.ir[11];
    assign src_b = cw.src2mux_sel ? if_id.ir[11:9] : if_id.ir[2:0];

    cpu_regfile regfile (
        .clk(clk),
        .rst(rst),
        .load(wb_load_regfile),
        .in(regfile_in),
        .src_a(if_id.ir[8:6]),
        .src_b(src_b),
        .dest(dest),
        .reg_a(reg_a),
        .reg_b(reg_b)
    );

    always_ff @(posedge clk) begin
        id_ex.ex <= cw.ex;
        id_ex.mem <= cw.mem;
        id_ex.wb <= cw.wb;
        id_ex.pc <= if_id.pc;
        id_ex.ir <= if_id.ir;
        id_ex.src_a_data <= reg_a;
        id_ex.src_b_data <= reg_b;
        if (rst) begin
            id_ex.valid <= 1'b0;
        end else begin
            id_ex.valid <= if_id.valid;
        end
    end

    // Execute
    assign imm4 = {12'h000, id_ex.ir[3:0]};
    assign imm5 = {{11{id_ex.ir[4]}}, id_ex.ir[4:0]};
    assign off6 = id_ex.ex.offset6_lsse ? {{9{id_ex.ir[5]}}, id_ex.ir[5:0], 1'b0}
                                        : {{10{id_ex.ir[5]}}, id_ex.ir[5:0]};

    always_comb begin
        case (id_ex.ex.alumux_sel)
            alumux_imm4: alumux_out = imm4;
            alumux_imm5: alumux_out = imm5;
            alumux_off6: alumux_out = off6;
            default:     alumux_out = id_ex.src_b_data;
        endcase
    end

    cpu_alu alu (
        .aluop(id_ex.ex.aluop),
        .a(id_ex.src_a_data),
        .b(alumux_out),
        .f(alu_out)
    );

    // Byte lane for STB follows address bit 0
    always_comb begin
        store_mask = 2'b11;
        store_data = id_ex.src_b_data;
        if (id_ex.wb.opcode == op_stb) begin
            if (alu_out[0]) begin
                store_mask = 2'b10;
                store_data = {id_ex.src_b_data[7:0], 8'h00};
            end else begin
                store_mask = 2'b01;
                store_data = {8'h00, id_ex.src_b_data[7:0]};
            end
        end
    end

    always_ff @(posedge clk) begin
        ex_mem.mem <= id_ex.mem;
        ex_mem.wb <= id_ex.wb;
        ex_mem.pc <= id_ex.pc;
        ex_mem.ir <= id_ex.ir;
        ex_mem.alu <= alu_out;
        ex_mem.wdata <= store_data;
        ex_mem.wmask <= store_mask;
        if (rst) begin
            ex_mem.valid <= 1'b0;
        end else begin
            ex_mem.valid <= id_ex.valid;
        end
    end

    // Memory
    assign d_mem_address = ex_mem.alu;
    assign d_mem_wdata = ex_mem.wdata;
    assign d_mem_byte_enable = ex_mem.wmask;
    assign d_mem_read = ex_mem.valid && ex_mem.mem.d_mem_read;
    assign d_mem_write = ex_mem.valid && ex_mem.mem.d_mem_write;

    always_ff @(posedge clk) begin
        mem_wb.wb <= ex_mem.wb;
        mem_wb.pc <= ex_mem.pc;
        mem_wb.ir <= ex_mem.ir;
        mem_wb.alu <= ex_mem.alu;
        mem_wb.rdata <= d_mem_rdata;
        if (rst) begin
            mem_wb.valid <= 1'b0;
        end else begin
            mem_wb.valid <= ex_mem.valid;
        end
    end

    // Writeback
    assign adj9 = {{6{mem_wb.ir[8]}}, mem_wb.ir[8:0], 1'b0};
    assign adj11 = {{4{mem_wb.ir[10]}}, mem_wb.ir[10:0], 1'b0};
    assign pc_plus_off = mem_wb.pc + ((mem_wb.wb.opcode == op_jsr) ? adj11 : adj9);
    assign dest = mem_wb.wb.destmux_sel ? 3'b111 : mem_wb.ir[11:9];
    assign wb_load_regfile = mem_wb.valid && mem_wb.wb.load_regfile;

    // LDB picks the addressed byte and zero-extends it
    always_comb begin
        load_data = mem_wb.rdata;
        if (mem_wb.wb.opcode == op_ldb) begin
            load_data = mem_wb.alu[0] ? {8'h00, mem_wb.rdata[15:8]}
                                      : {8'h00, mem_wb.rdata[7:0]};
        end
    end

    always_comb begin
        case (mem_wb.wb.regfilemux_sel)
            regfilemux_mem:   regfile_in = load_data;
            regfilemux_pcoff: regfile_in = pc_plus_off;
            regfilemux_link:  regfile_in = mem_wb.pc;
            default:          regfile_in = mem_wb.alu;
        endcase
    end

    assign gencc = regfile_in[15] ? 3'b100 : ((regfile_in == '0) ? 3'b010 : 3'b001);

    always_ff @(posedge clk) begin
        if (rst) begin
            cc <= '0;
        end else if (mem_wb.valid && mem_wb.wb.load_cc) begin
            cc <= gencc;
        end
    end

    // BR nzp lives in the DR field
    assign br_enable = |(cc & mem_wb.ir[11:9]);

    always_comb begin
        pc_next = pc_plus2;
        if (mem_wb.valid) begin
            case (mem_wb.wb.opcode)
                op_br: begin
                    if (br_enable) begin
                        pc_next = pc_plus_off;
                    end
                end
                op_jmp: begin
                    pc_next = mem_wb.alu;
                end
                op_jsr: begin
                    pc_next = mem_wb.ir[11] ? pc_plus_off : mem_wb.alu;
                end
                default: begin
                    pc_next = pc_plus2;
                end
            endcase
        end
    end

endmodule : cpu_datapath

// File: logic/lc3b_cpu.sv
`timescale 1ns/1ps

module lc3b_cpu #(
    parameter lc3b_types::lc3b_word start_pc = '0
) (
    input  logic                      clk,
    input  logic                      rst,

    // Instruction memory
    output lc3b_types::lc3b_word      i_mem_address,
    input  lc3b_types::lc3b_word      i_mem_rdata,

    // Data memory
    output lc3b_types::lc3b_word      d_mem_address,
    input  lc3b_types::lc3b_word      d_mem_rdata,
    output lc3b_types::lc3b_word      d_mem_wdata,
    output logic                      d_mem_read,
    output logic                      d_mem_write,
    output lc3b_types::lc3b_mem_wmask d_mem_byte_enable
);
    import lc3b_types::*;

    lc3b_control_word cw;
    lc3b_opcode       opcode;
    logic             ir_4;
    logic             ir_5;
    logic             ir_11;

    // Decode of the instruction sitting in IF/ID
    cpu_control control (
        .opcode(opcode),
        .ir_4(ir_4),
        .ir_5(ir_5),
        .ir_11(ir_11),
        .cw(cw)
    );

    cpu_datapath #(
        .start_pc(start_pc)
    ) datapath (
        .clk(clk),
        .rst(rst),
        .cw(cw),
        .opcode(opcode),
        .ir_4(ir_4),
        .ir_5(ir_5),
        .ir_11(ir_11),
        .i_mem_address(i_mem_address),
        .i_mem_rdata(i_mem_rdata),
        .d_mem_address(d_mem_address),
        .d_mem_rdata(d_mem_rdata),
        .d_mem_wdata(d_mem_wdata),
        .d_mem_read(d_mem_read),
        .d_mem_write(d_mem_write),
        .d_mem_byte_enable(d_mem_byte_enable)
    );

endmodule : lc3b_cpu

// File: verification/lc3b_cpu_assertions.sv
`timescale 1ns/1ps

module lc3b_cpu_assertions (
    input logic                      clk,
    input logic                      rst,
    input lc3b_types::lc3b_word      d_mem_address,
    input logic                      d_mem_read,
    input logic                      d_mem_write,
    input lc3b_types::lc3b_mem_wmask d_mem_byte_enable
);
    import lc3b_types::*;

    // Number of failed assertions
    int unsigned failures = 0;

    // One shared data port never reads and writes at once
    read_write_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(d_mem_read && d_mem_write))
        else begin
            failures++;
            $error("data read and write strobes high together");
        end

    // Valid bits are cleared by any reset edge
    quiet_after_reset: assert property (@(posedge clk)
        rst |=> !(d_mem_read || d_mem_write))
        else begin
            failures++;
            $error("data strobe high right after a reset edge");
        end

    // A byte store enables only the lane that address bit 0 selects
    write_has_lanes: assert property (@(posedge clk) disable iff (rst)
        d_mem_write |-> d_mem_byte_enable == 2'b11
            || d_mem_byte_enable == {d_mem_address[0], !d_mem_address[0]})
        else begin
            failures++;
            $error("write strobe with a byte enable that matches no lane");
        end

endmodule : lc3b_cpu_assertions

bind lc3b_cpu lc3b_cpu_assertions strobe_checks (.*);

// File: verification/lc3b_cpu_tb.sv
`timescale 1ns/1ps

module lc3b_cpu_tb;
    import lc3b_types::*;

    localparam lc3b_word start_pc = 16'h0040;
    localparam int num_tests = 6;

    logic          clk;
    logic          rst;
    lc3b_word      i_mem_address;
    lc3b_word      i_mem_rdata;
    lc3b_word      d_mem_address;
    lc3b_word      d_mem_rdata;
    lc3b_word      d_mem_wdata;
    logic          d_mem_read;
    logic          d_mem_write;
    lc3b_mem_wmask d_mem_byte_enable;

    // 4 KiB byte memories that ignore the upper address bits
    logic [7:0] imem [4096];
    logic [7:0] dmem [4096];
    logic [7:0] ref_mem [4096];
    logic [15:0] lfsr_state = 16'd20;

    lc3b_word      prog [$];
    int            test_of [$];
    lc3b_word      exp_addr [$];
    lc3b_word      exp_data [$];
    lc3b_mem_wmask exp_mask [$];
    int            exp_test [$];

    lc3b_cpu #(.start_pc(start_pc)) UUT (.*);

    assign i_mem_rdata = {imem[{i_mem_address[11:1], 1'b1}], imem[{i_mem_address[11:1], 1'b0}]};
    assign d_mem_rdata = {dmem[{d_mem_address[11:1], 1'b1}], dmem[{d_mem_address[11:1], 1'b0}]};

    always @(posedge clk) begin
        if (d_mem_write === 1'b1) begin
            if (d_mem_byte_enable[1]) begin
                dmem[{d_mem_address[11:1], 1'b1}] <= d_mem_wdata[15:8];
            end
            if (d_mem_byte_enable[0]) begin
                dmem[{d_mem_address[11:1], 1'b0}] <= d_mem_wdata[7:0];
            end
        end
    end

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Fibonacci LFSR with taps 16 14 13 11
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        return fb;
    endfunction

    function automatic string test_name(int id);
        case (id)
            0: return "reset";
            1: return "alu_shift";
            2: return "byte_store";
            3: return "load";
            4: return "branch";
            default: return "jump_lea";
        endcase
    endfunction

    task automatic fail_now(string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic check_word(string name, lc3b_word expected, lc3b_word actual);
        if (actual !== expected) begin
            fail_now($sformatf("Error in %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    task automatic check_mask(string name, lc3b_mem_wmask expected, lc3b_mem_wmask actual);
        if (actual !== expected) begin
            fail_now($sformatf("Error in %s: expected mask %b, actual %b", name, expected,
                               actual));
        end
    endtask

    function automatic lc3b_word enc(lc3b_opcode op, lc3b_reg dr, lc3b_reg sr, logic [5:0] low);
        return {op, dr, sr, low};
    endfunction

    function automatic lc3b_word enc9(lc3b_opcode op, logic [2:0] f, logic [8:0] off);
        return {op, f, off};
    endfunction

    // Instruction followed by its NOP padding
    task automatic emit(lc3b_word w, int t, int pad);
        prog.push_back(w);
        test_of.push_back(t);
        repeat (pad) begin
            prog.push_back(16'h0000);
            test_of.push_back(t);
        end
    endtask

    // Taken branch skips the store of R2
    task automatic emit_branch_case(lc3b_word setup, logic [2:0] nzp, logic [5:0] off);
        emit(setup, 4, 2);
        emit(enc9(op_br, nzp, 9'd7), 4, 4);
        emit(enc(op_str, 2, 6, off), 4, 2);
    endtask

    task automatic build_program();
        // R6 = 0x0800 with random operands just below it
        emit(enc(op_add, 6, 0, {1'b1, 5'd8}), 0, 2);
        emit(enc(op_shf, 6, 6, {2'b00, 4'd8}), 0, 2);
        emit(enc(op_ldr, 1, 6, 6'h3F), 0, 2);
        emit(enc(op_ldr, 2, 6, 6'h3E), 0, 2);
        emit(enc(op_ldr, 3, 6, 6'h3D), 0, 2);
        emit(enc(op_add, 4, 1, 6'd2), 1, 2);
        emit(enc(op_str, 4, 6, 6'd0), 1, 2);
        emit(enc(op_add, 4, 1, {1'b1, 5'h19}), 1, 2);
        emit(enc(op_str, 4, 6, 6'd1), 1, 2);
        emit(enc(op_and, 4, 1, 6'd2), 1, 2);
        emit(enc(op_str, 4, 6, 6'd2), 1, 2);
        emit(enc(op_and, 4, 1, {1'b1, 5'd13}), 1, 2);
        emit(enc(op_str, 4, 6, 6'd3), 1, 2);
        emit(enc(op_not, 4, 1, 6'h3F), 1, 2);
        emit(enc(op_str, 4, 6, 6'd4), 1, 2);
        emit(enc(op_shf, 4, 1, {2'b00, 4'd3}), 1, 2);
        emit(enc(op_str, 4, 6, 6'd5), 1, 2);
        emit(enc(op_shf, 4, 3, {2'b01, 4'd5}), 1, 2);
        emit(enc(op_str, 4, 6, 6'd6), 1, 2);
        emit(enc(op_shf, 4, 3, {2'b11, 4'd11}), 1, 2);
        emit(enc(op_str, 4, 6, 6'd7), 1, 2);
        emit(enc(op_shf, 4, 1, {2'b11, 4'd4}), 1, 2);
        emit(enc(op_str, 4, 6, 6'd8), 1, 2);
        emit(enc(op_stb, 1, 6, 6'd20), 2, 2);
        emit(enc(op_stb, 2, 6, 6'd21), 2, 2);
        emit(enc(op_stb, 3, 6, 6'd23), 2, 2);
        emit(enc(op_ldr, 4, 6, 6'h3C), 3, 2);
        emit(enc(op_str, 4, 6, 6'd12), 3, 2);
        emit(enc(op_ldb, 4, 6, 6'h3B), 3, 2);
        emit(enc(op_str, 4, 6, 6'd13), 3, 2);
        emit(enc(op_ldb, 4, 6, 6'h3A), 3, 2);
        emit(enc(op_str, 4, 6, 6'd14), 3, 2);
        emit_branch_case(enc(op_add, 4, 1, {1'b1, 5'd0}), 3'b100, 6'd24);
        emit_branch_case(enc(op_add, 4, 2, {1'b1, 5'd0}), 3'b011, 6'd25);
        emit_branch_case(enc(op_and, 4, 1, {1'b1, 5'd0}), 3'b010, 6'd26);
        emit_branch_case(enc(op_and, 4, 1, {1'b1, 5'd0}), 3'b101, 6'd27);
        emit_branch_case(enc(op_not, 4, 0, 6'h3F), 3'b001, 6'd28);
        emit(enc9(op_lea, 4, 9'h1F0), 5, 2);
        emit(enc(op_str, 4, 6, 6'd17), 5, 2);
        emit(enc9(op_jsr, 3'b100, 9'd7), 5, 4);
        emit(enc(op_str, 2, 6, 6'd18), 5, 2);
        emit(enc(op_str, 7, 6, 6'd19), 5, 2);
        emit(enc9(op_lea, 5, 9'd10), 5, 2);
        emit(enc(op_jmp, 0, 5, 6'd0), 5, 4);
        emit(enc(op_str, 2, 6, 6'd20), 5, 2);
        emit(enc9(op_lea, 5, 9'd10), 5, 2);
        emit(enc(op_jsr, 0, 5, 6'd0), 5, 4);
        emit(enc(op_str, 2, 6, 6'd21), 5, 2);
        emit(enc(op_str, 7, 6, 6'd22), 5, 2);
        // Branch always to itself ends the program
        emit(16'h0FFF, 5, 0);
    endtask

    // Instruction-level model of the kept LC-3b subset
    function automatic void run_reference();
        lc3b_word r [8];
        lc3b_word pc;
        lc3b_word ir;
        lc3b_word pc_n;
        lc3b_word res;
        lc3b_word addr;
        lc3b_word off9;
        lc3b_nzp  cc;
        logic     setcc;
        int       a;
        int       t;
        for (int i = 0; i < 8; i++) begin
            r[i] = '0;
        end
        cc = '0;
        pc = start_pc;
        for (int step = 0; step < 10000; step++) begin
            ir = {imem[pc[11:0] | 1], imem[pc[11:0] & 12'hFFE]};
            if (ir == 16'h0FFF) begin
                break;
            end
            t = test_of[(pc - start_pc) >> 1];
            pc_n = pc + 16'd2;
            off9 = {{6{ir[8]}}, ir[8:0], 1'b0};
            setcc = 1'b0;
            res = '0;
            case (ir[15:12])
                4'b0001, 4'b0101: begin
                    res = ir[5] ? {{11{ir[4]}}, ir[4:0]} : r[ir[2:0]];
                    res = (ir[15:12] == 4'b0001) ? r[ir[8:6]] + res : r[ir[8:6]] & res;
                    setcc = 1'b1;
                end
                4'b1001: begin
                    res = ~r[ir[8:6]];
                    setcc = 1'b1;
                end
                4'b1101: begin
                    if (!ir[4]) begin
                        res = r[ir[8:6]] << ir[3:0];
                    end else if (!ir[5]) begin
                        res = r[ir[8:6]] >> ir[3:0];
                    end else begin
                        res = $signed(r[ir[8:6]]) >>> ir[3:0];
                    end
                    setcc = 1'b1;
                end
                4'b1110: r[ir[11:9]] = pc_n + off9;
                4'b0110, 4'b0111: begin
                    addr = r[ir[8:6]] + {{9{ir[5]}}, ir[5:0], 1'b0};
                    a = addr[11:0];
                    if (ir[12]) begin
                        ref_mem[a] = r[ir[11:9]][7:0];
                        ref_mem[a | 1] = r[ir[11:9]][15:8];
                        exp_addr.push_back(addr);
                        exp_data.push_back(r[ir[11:9]]);
                        exp_mask.push_back(2'b11);
                        exp_test.push_back(t);
                    end else begin
                        res = {ref_mem[a | 1], ref_mem[a]};
                        setcc = 1'b1;
                    end
                end
                4'b0010, 4'b0011: begin
                    addr = r[ir[8:6]] + {{10{ir[5]}}, ir[5:0]};
                    a = addr[11:0];
                    if (ir[12]) begin
                        ref_mem[a] = r[ir[11:9]][7:0];
                        exp_addr.push_back(addr);
                        exp_data.push_back(addr[0] ? {r[ir[11:9]][7:0], 8'h00}
                                                   : {8'h00, r[ir[11:9]][7:0]});
                        exp_mask.push_back(addr[0] ? 2'b10 : 2'b01);
                        exp_test.push_back(t);
                    end else begin
                        res = {8'h00, ref_mem[a]};
                        setcc = 1'b1;
                    end
                end
                4'b0000: begin
                    if (|(ir[11:9] & cc)) begin
                        pc_n = pc_n + off9;
                    end
                end
                4'b1100: pc_n = r[ir[8:6]];
                4'b0100: begin
                    pc_n = ir[11] ? pc_n + {{4{ir[10]}}, ir[10:0], 1'b0} : r[ir[8:6]];
                    r[7] = pc + 16'd2;
                end
                default: ;
            endcase
            if (setcc) begin
                r[ir[11:9]] = res;
                cc = res[15] ? 3'b100 : ((res == '0) ? 3'b010 : 3'b001);
            end
            pc = pc_n;
        end
    endfunction

    task automatic stop_on_timeout(int limit_ns);
        #(limit_ns);
        fail_now($sformatf("Timeout: %0d expected stores never appeared", exp_addr.size()));
    endtask

    // Comparison of every store seen on the data port
    initial begin
        forever begin
            @(negedge clk);
            if (UUT.strobe_checks.failures != 0) begin
                fail_now("A bound assertion on the data strobes failed");
            end
            if (rst === 1'b0 && d_mem_write === 1'b1) begin
                if (exp_addr.size() == 0) begin
                    fail_now("Store seen on the data port after the last expected store");
                end
                check_word(test_name(exp_test[0]), exp_addr.pop_front(), d_mem_address);
                check_word(test_name(exp_test[0]), exp_data.pop_front(), d_mem_wdata);
                check_mask(test_name(exp_test[0]), exp_mask.pop_front(), d_mem_byte_enable);
                void'(exp_test.pop_front());
            end
        end
    end

    initial begin
        int first_mem;
        rst = 1'b1;
        first_mem = -1;
        for (int a = 0; a < 4096; a++) begin
            imem[a] = 8'h00;
            for (int b = 0; b < 8; b++) begin
                dmem[a][b] = lfsr_bit();
            end
            ref_mem[a] = dmem[a];
        end
        build_program();
        for (int i = 0; i < prog.size(); i++) begin
            imem[start_pc[11:0] + 2 * i] = prog[i][7:0];
            imem[start_pc[11:0] + 2 * i + 1] = prog[i][15:8];
            if (first_mem < 0 && prog[i][13:12] inside {2'b10, 2'b11}
                && prog[i][15:14] != 2'b11) begin
                first_mem = i;
            end
        end
        run_reference();
        fork
            stop_on_timeout((prog.size() + 20) * 10 * num_tests);
        join_none
        repeat (8) @(posedge clk);
        #1 rst = 1'b0;
        // Instruction k is fetched k cycles after release and is in MEM 3 cycles later
        for (int c = 0; c <= first_mem + 3; c++) begin
            @(negedge clk);
            if (c == 0) begin
                check_word(test_name(0), start_pc, i_mem_address);
            end
            if (c < first_mem + 3 && (d_mem_read !== 1'b0 || d_mem_write !== 1'b0)) begin
                fail_now("Data strobe high before the first load reached MEM");
            end
            if (c == first_mem + 3 && d_mem_read !== 1'b1) begin
                fail_now("First load did not raise the read strobe in MEM");
            end
        end
        // The whole program has been fetched well within this bound
        for (int c = 0; c < prog.size() + 20 && exp_addr.size() != 0; c++) begin
            @(negedge clk);
        end
        repeat (30) @(negedge clk);
        if (exp_addr.size() == 0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            fail_now($sformatf("%0d expected stores never appeared on the data port",
                               exp_addr.size()));
        end
    end

endmodule : lc3b_cpu_tb

// File: lc3b_cpu.f
logic/lc3b_types.sv
logic/cpu_control.sv
logic/cpu_regfile.sv
logic/cpu_alu.sv
logic/cpu_datapath.sv
logic/lc3b_cpu.sv
verification/lc3b_cpu_assertions.sv
verification/lc3b_cpu_tb.sv

// File: Bender.yml
package:
  name: lc3b_cpu

sources:
  - logic/lc3b_types.sv
  - logic/cpu_control.sv
  - logic/cpu_regfile.sv
  - logic/cpu_alu.sv
  - logic/cpu_datapath.sv
  - logic/lc3b_cpu.sv
  - target: test
    files:
      - verification/lc3b_cpu_assertions.sv
      - verification/lc3b_cpu_tb.sv
